// ==== list.f ====
common/shade_cfg_pkg.sv
common/shade_fsm_pkg.sv
common/shade_if.sv
design/patch_ctrl/patch_ctrl.sv
design/patch_dispatch/patch_dispatch.sv
design/pixel_mem/pixel_mem.sv
design/shade_top.sv
tb/shade_properties.sv
tb/shade_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= shade_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/shade_tb.sv ====
`timescale 1ns/1ps

module shade_tb;
    import shade_cfg_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        host_we;
    pixel_id_t   host_addr;
    pixel_t      host_wdata;
    logic        size_we;
    frame_size_t frame_size;
    logic        frame_start;
    gain_t       gain;
    pixel_id_t   rd_addr;
    pixel_t      rd_data;
    logic        frame_done;

    pixel_t model [MEM_DEPTH];
    integer seed;
    int     error_count = 0;
    int     done_count = 0;

    shade_top shade_top_inst (.*);

    bind shade_top shade_properties shade_properties_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .frame_done  (frame_done),
        .rd_data     (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // count frame_done pulses away from the rising edge.
    always @(negedge clk) begin
        if (frame_done === 1'b1) begin
            done_count++;
        end
    end

    // gain is 4.4 fixed point, result clips at 255.
    function automatic pixel_t expected_shade(input pixel_t pix, input gain_t g);
        int scaled;
        scaled = (int'(pix) * int'(g)) / 16;
        return (scaled > 255) ? pixel_t'(255) : pixel_t'(scaled);
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic fill_memory();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            host_we = 1'b1;
            host_addr = pixel_id_t'(a);
            host_wdata = pixel_t'($random(seed));
            model[a] = host_wdata;
            tick();
        end
        host_we = 1'b0;
    endtask

    task automatic configure_frame(input int size, input gain_t g);
        size_we = 1'b1;
        frame_size = frame_size_t'(size);
        gain = g;
        tick();
        size_we = 1'b0;
        tick();
    endtask

    task automatic pulse_start();
        frame_start = 1'b1;
        tick();
        frame_start = 1'b0;
    endtask

    // with restart set, frame_start is pulsed every other cycle while the frame runs.
    task automatic wait_frame_done(input bit restart);
        int cycles;
        cycles = 0;
        while (frame_done !== 1'b1 && cycles < 2000) begin
            frame_start = restart && !cycles[0];
            tick();
            frame_start = 1'b0;
            cycles++;
        end
        if (frame_done !== 1'b1) begin
            error_count++;
            $display("frame_done did not arrive within 2000 cycles, time %0t", $time);
        end
        tick();
    endtask

    task automatic shade_model(input int size, input gain_t g);
        for (int a = 0; a < size; a++) begin
            model[a] = expected_shade(model[a], g);
        end
    endtask

    task automatic run_frame(input int size, input gain_t g);
        configure_frame(size, g);
        pulse_start();
        wait_frame_done(1'b0);
        shade_model(size, g);
    endtask

    // host read data shows one cycle after its address.
    task automatic check_memory();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            rd_addr = pixel_id_t'(a);
            tick();
            assert (rd_data === model[a]) else begin
                error_count++;
                $display("Mismatch at %0t: rd_data (addr %0d) expected %02h actual %02h",
                         $time, a, model[a], rd_data);
            end
        end
        rd_addr = '0;
    endtask

    initial begin
        int done_before;
        seed = 32'hd8fc;
        rst_n = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        size_we = 1'b0;
        frame_size = '0;
        frame_start = 1'b0;
        gain = 8'd16;
        rd_addr = '0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick();

        // two full batches at unity gain.
        fill_memory();
        run_frame(64, 8'd16);
        check_memory();

        // one full batch and an 8 lane tail.
        fill_memory();
        run_frame(40, 8'd40);
        check_memory();

        fill_memory();
        run_frame(1, 8'd28);
        check_memory();

        // second frame shades the output of the first.
        fill_memory();
        run_frame(256, 8'd12);
        run_frame(33, 8'd30);
        check_memory();

        // starts keep coming for the whole frame and must all be dropped.
        fill_memory();
        configure_frame(100, 8'd20);
        done_before = done_count;
        pulse_start();
        wait_frame_done(1'b1);
        repeat (300) tick();
        assert (done_count == done_before + 1) else begin
            error_count++;
            $display("expected one frame_done for the frame, saw %0d", done_count - done_before);
        end
        shade_model(100, 8'd20);
        check_memory();

        error_count += shade_top_inst.shade_properties_inst.fail_count;
        $display("checks complete, %0d errors", error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/shade_properties.sv ====
`timescale 1ns/1ps

module shade_properties (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  frame_start,
    input logic                  frame_done,
    input shade_cfg_pkg::pixel_t rd_data
);

    logic start_pending;
    logic started;
    int   fail_count = 0;

    // a start opens a frame, frame_done closes it.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_pending <= 1'b0;
            started <= 1'b0;
        end else begin
            if (frame_start) begin
                start_pending <= 1'b1;
                started <= 1'b1;
            end else if (frame_done) begin
                start_pending <= 1'b0;
            end
        end
    end

    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |=> !frame_done)
        else begin
            $error("frame_done stayed high for more than one cycle");
            fail_count++;
        end

    done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> start_pending)
        else begin
            $error("frame_done without a preceding frame_start");
            fail_count++;
        end

    // memory is fully written before the first frame.
    rd_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        started |-> !$isunknown(rd_data))
        else begin
            $error("rd_data is unknown");
            fail_count++;
        end

endmodule

// ==== design/shade_top.sv ====
`timescale 1ns/1ps

module shade_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       host_we,
    input  shade_cfg_pkg::pixel_id_t   host_addr,
    input  shade_cfg_pkg::pixel_t      host_wdata,
    input  logic                       size_we,
    input  shade_cfg_pkg::frame_size_t frame_size,
    input  logic                       frame_start,
    input  shade_cfg_pkg::gain_t       gain,
    input  shade_cfg_pkg::pixel_id_t   rd_addr,
    output shade_cfg_pkg::pixel_t      rd_data,
    output logic                       frame_done
);

    patch_if   pd_bus ();
    mem_if     mem_bus ();
    mc_ctrl_if mc_bus ();

    patch_ctrl patch_ctrl_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .mc    (mc_bus.cp),
        .pd    (pd_bus.ctrl)
    );

    patch_dispatch patch_dispatch_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .gain  (gain),
        .pd    (pd_bus.disp),
        .mem   (mem_bus.master)
    );

    pixel_mem pixel_mem_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .host_we     (host_we),
        .host_addr   (host_addr),
        .host_wdata  (host_wdata),
        .size_we     (size_we),
        .frame_size  (frame_size),
        .frame_start (frame_start),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .frame_done  (frame_done),
        .mem         (mem_bus.slave),
        .mc          (mc_bus.mc)
    );

endmodule

// ==== design/pixel_mem/pixel_mem.sv ====
`timescale 1ns/1ps

module pixel_mem (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       host_we,
    input  shade_cfg_pkg::pixel_id_t   host_addr,
    input  shade_cfg_pkg::pixel_t      host_wdata,
    input  logic                       size_we,
    input  shade_cfg_pkg::frame_size_t frame_size,
    input  logic                       frame_start,
    input  shade_cfg_pkg::pixel_id_t   rd_addr,
    output shade_cfg_pkg::pixel_t      rd_data,
    output logic                       frame_done,
    mem_if.slave                       mem,
    mc_ctrl_if.mc                      mc
);
    import shade_cfg_pkg::*;

    pixel_t      store [MEM_DEPTH];
    pixel_t      rd_q;
    frame_size_t size_q;
    logic        we_ps_q;
    logic        init_q;
    logic        pod_q;
    logic        done_q;
    logic        busy;
    logic        term;

    assign mem.rd_data = rd_q;
    assign mc.pixel_size = size_q;
    assign mc.we_ps = we_ps_q;
    assign mc.init_mem_fin = init_q;
    assign mc.patch_out_done = pod_q;
    assign frame_done = done_q;

    // write-back has priority, host access only between frames.
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            store[mem.wr_addr] <= mem.wr_data;
        end else if (host_we) begin
            store[host_addr] <= host_wdata;
        end
        if (mem.rd_en) begin
            rd_q <= store[mem.rd_addr];
        end
        rd_data <= store[rd_addr];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            size_q <= '0;
            we_ps_q <= 1'b0;
            init_q <= 1'b0;
            pod_q <= 1'b0;
            done_q <= 1'b0;
            busy <= 1'b0;
            term <= 1'b0;
        end else begin
            we_ps_q <= size_we;
            init_q <= 1'b0;
            pod_q <= 1'b0;
            done_q <= 1'b0;
            if (size_we) begin
                size_q <= frame_size;
            end
            // a start while busy is dropped.
            if (frame_start && !busy) begin
                busy <= 1'b1;
                init_q <= 1'b1;
            end
            if (mc.load_done_term) begin
                term <= 1'b1;
            end
            if (mem.wr_en && mem.wr_last) begin
                if (term) begin
                    done_q <= 1'b1;
                    busy <= 1'b0;
                    term <= 1'b0;
                end else begin
                    pod_q <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/patch_dispatch/patch_dispatch.sv ====
`timescale 1ns/1ps

module patch_dispatch (
    input logic                 clk,
    input logic                 rst_n,
    input shade_cfg_pkg::gain_t gain,
    patch_if.disp               pd,
    mem_if.master               mem
);
    import shade_cfg_pkg::*;
    import shade_fsm_pkg::*;

    disp_state_t state;

    lane_t     lane_ptr;
    lane_t     lane_sel;
    lane_t     last_lane;
    lane_t     cap_lane;
    lane_t     wr_lane;
    logic      cap_valid;
    pixel_id_t lane_id [NUM_THREAD];
    pixel_t    lane_pix [NUM_THREAD];

    // pixel * gain, drop the fraction, clip.
    function automatic pixel_t shade(input pixel_t pix, input gain_t g);
        logic [15:0] prod;
        logic [15:0] scaled;
        prod = pix * g;
        scaled = prod >> GAIN_FRAC;
        if (scaled > PIX_MAX) begin
            return pixel_t'(PIX_MAX);
        end
        return scaled[7:0];
    endfunction

    // a new batch always starts at lane 0.
    assign lane_sel = pd.load_start ? '0 : lane_ptr;

    assign mem.rd_en = pd.load_valid;
    assign mem.rd_addr = pd.pixel_id;

    assign mem.wr_en = (state == d_write);
    assign mem.wr_addr = lane_id[wr_lane];
    assign mem.wr_data = lane_pix[wr_lane];
    assign mem.wr_last = (state == d_write) && (wr_lane == last_lane);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lane_ptr <= '0;
            last_lane <= '0;
            cap_valid <= 1'b0;
            cap_lane <= '0;
        end else begin
            cap_valid <= pd.load_valid;
            if (pd.load_valid) begin
                lane_ptr <= lane_sel + 1'b1;
                last_lane <= lane_sel;
                cap_lane <= lane_sel;
            end
        end
    end

    // lane payload, read data lands one cycle after its id.
    always_ff @(posedge clk) begin
        if (pd.load_valid) begin
            lane_id[lane_sel] <= pd.pixel_id;
        end
        if (cap_valid) begin
            lane_pix[cap_lane] <= mem.rd_data;
        end else if (state == d_shade) begin
            for (int i = 0; i < NUM_THREAD; i++) begin
                lane_pix[i] <= shade(lane_pix[i], gain);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= d_idle;
            wr_lane <= '0;
        end else begin
            case (state)
                d_idle: begin
                    if (pd.load_start) begin
                        state <= d_load;
                    end
                end
                d_load: begin
                    if (pd.load_done) begin
                        state <= d_shade;
                    end
                end
                d_shade: begin
                    wr_lane <= '0;
                    state <= d_write;
                end
                default: begin
                    // write back in lane order.
                    wr_lane <= wr_lane + 1'b1;
                    if (wr_lane == last_lane) begin
                        state <= d_idle;
                    end
                end
            endcase
        end
    end

endmodule

// ==== design/patch_ctrl/patch_ctrl.sv ====
`timescale 1ns/1ps

module patch_ctrl (
    input logic clk,
    input logic rst_n,
    mc_ctrl_if.cp mc,
    patch_if.ctrl pd
);
    import shade_cfg_pkg::*;
    import shade_fsm_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next;

    lane_t     thread_cnt;
    lane_t     thread_cnt_in;
    pixel_id_t pixel_max;
    pixel_id_t pixel_curr;
    pixel_id_t pixel_curr_in;
    logic      load_done_q;
    logic      load_done_in;
    logic      issue;

    assign pd.pixel_id = pixel_curr;
    assign pd.load_done = load_done_q;

    // last id of the frame, taken when the size is written.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_max <= '0;
        end else if (mc.we_ps) begin
            pixel_max <= pixel_id_t'(mc.pixel_size - frame_size_t'(1));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            thread_cnt <= '0;
            pixel_curr <= '0;
            load_done_q <= 1'b0;
        end else begin
            state <= next;
            thread_cnt <= thread_cnt_in;
            pixel_curr <= pixel_curr_in;
            load_done_q <= load_done_in;
        end
    end

    always_comb begin
        next = state;
        thread_cnt_in = thread_cnt;
        pixel_curr_in = pixel_curr;
        load_done_in = 1'b0;
        pd.load_start = 1'b0;
        pd.load_valid = 1'b0;
        mc.load_done_term = 1'b0;
        issue = 1'b0;

        case (state)
            idle: begin
                if (mc.init_mem_fin) begin
                    issue = 1'b1;
                    pd.load_start = 1'b1;
                end
            end
            patching_wait: begin
                if (mc.patch_out_done) begin
                    issue = 1'b1;
                    pd.load_start = 1'b1;
                end
            end
            default: begin
                issue = 1'b1;
            end
        endcase

        // one id per cycle until the batch is full or the frame ends.
        if (issue) begin
            pd.load_valid = 1'b1;
            if (pixel_curr == pixel_max) begin
                next = idle;
                thread_cnt_in = '0;
                pixel_curr_in = '0;
                load_done_in = 1'b1;
                mc.load_done_term = 1'b1;
            end else if (&thread_cnt) begin
                next = patching_wait;
                thread_cnt_in = '0;
                pixel_curr_in = pixel_curr + 1'b1;
                load_done_in = 1'b1;
            end else begin
                next = patching;
                thread_cnt_in = thread_cnt + 1'b1;
                pixel_curr_in = pixel_curr + 1'b1;
            end
        end
    end

endmodule

// ==== common/shade_if.sv ====
`timescale 1ns/1ps

// pixel ids from the sequencer to the dispatcher.
interface patch_if;
    import shade_cfg_pkg::*;

    logic      load_start;
    logic      load_valid;
    pixel_id_t pixel_id;
    logic      load_done;

    modport ctrl (output load_start, output load_valid, output pixel_id, output load_done);
    modport disp (input load_start, input load_valid, input pixel_id, input load_done);
endinterface

// dispatcher access to frame storage.
interface mem_if;
    import shade_cfg_pkg::*;

    logic      rd_en;
    pixel_id_t rd_addr;
    pixel_t    rd_data;
    logic      wr_en;
    pixel_id_t wr_addr;
    pixel_t    wr_data;
    logic      wr_last;

    modport master (output rd_en, output rd_addr, input rd_data,
                    output wr_en, output wr_addr, output wr_data, output wr_last);
    modport slave (input rd_en, input rd_addr, output rd_data,
                   input wr_en, input wr_addr, input wr_data, input wr_last);
endinterface

// frame control between memory side and sequencer.
interface mc_ctrl_if;
    import shade_cfg_pkg::*;

    logic        init_mem_fin;
    logic        patch_out_done;
    logic        we_ps;
    frame_size_t pixel_size;
    logic        load_done_term;

    modport mc (output init_mem_fin, output patch_out_done, output we_ps,
                output pixel_size, input load_done_term);
    modport cp (input init_mem_fin, input patch_out_done, input we_ps,
                input pixel_size, output load_done_term);
endinterface

// ==== common/shade_fsm_pkg.sv ====
package shade_fsm_pkg;

    // batch sequencer states.
    typedef enum logic [1:0] {
        idle,
        patching,
        patching_wait
    } ctrl_state_t;

    // dispatcher states.
    typedef enum logic [1:0] {
        d_idle,
        d_load,
        d_shade,
        d_write
    } disp_state_t;

endpackage

// ==== common/shade_cfg_pkg.sv ====
package shade_cfg_pkg;

    // lanes per batch.
    localparam int NUM_THREAD = 32;
    localparam int LANE_W = $clog2(NUM_THREAD);

    // frame storage.
    localparam int MEM_DEPTH = 256;

    // gain is 4.4 fixed point, results clip at the pixel maximum.
    localparam int GAIN_FRAC = 4;
    localparam int PIX_MAX = 255;

    // pixel address.
    typedef logic [7:0] pixel_id_t;

    // pixel count, 1 to 256.
    typedef logic [8:0] frame_size_t;

    // pixel value.
    typedef logic [7:0] pixel_t;

    // shading gain.
    typedef logic [7:0] gain_t;

    // lane index inside a batch.
    typedef logic [LANE_W-1:0] lane_t;

endpackage
